/* hw/ipv4_frame_serializer.sv */
`timescale 1ns/1ps

module ipv4_frame_serializer #(
  parameter int len_w = 16
) (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  logic                    hdr_rdy,
  input  ipv4_tx_pkg::hdr_bytes_t hdr_bytes,
  input  logic [len_w-1:0]        frame_len,
  input  logic                    mac_req,
  input  logic                    pld_val,
  input  logic [7:0]              pld_dat,
  output logic                    mac_rdy,
  output ipv4_tx_pkg::byte_strm_t mac_strm,
  output logic                    pld_req,
  output logic                    frame_end,
  output logic                    underrun
);

  localparam logic [len_w-1:0] hdr_end  = len_w'(ipv4_tx_pkg::hdr_len);
  localparam logic [len_w-1:0] pld_call = len_w'(ipv4_tx_pkg::hdr_len - 4);  // byte 16

  ipv4_tx_pkg::hdr_bytes_t sh;

  logic             pend;   // mac_req seen, first byte next cycle
  logic             act;    // this cycle is a byte slot
  logic [len_w-1:0] cnt;    // index of the byte in the current slot
  logic             hdr_phase;
  logic             last;

  assign hdr_phase = cnt < hdr_end;
  assign last      = cnt == (frame_len - len_w'(1));

  assign mac_rdy  = hdr_rdy && !pend && !act;
  assign pld_req  = act && (cnt == pld_call);  // four slots of lead for the source
  assign underrun = act && !hdr_phase && !pld_val;

  // ------------------------------------------------------------
  // stream to the mac
  // ------------------------------------------------------------

  always_comb begin
    mac_strm.dat = hdr_phase ? sh[ipv4_tx_pkg::hdr_len-1] : pld_dat;
    mac_strm.val = act && (hdr_phase || pld_val);
    mac_strm.sof = act && (cnt == '0);
    mac_strm.eof = mac_strm.val && last;  // an underrun slot never carries eof
  end

  assign frame_end = mac_strm.eof;

  // ------------------------------------------------------------
  // slot counter
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      pend <= 1'b0;
      act  <= 1'b0;
      cnt  <= '0;
    end else begin
      pend <= mac_req && mac_rdy;
      if (pend) begin
        act <= 1'b1;
        cnt <= '0;
      end else if (act) begin
        cnt <= cnt + len_w'(1);
        if (mac_strm.eof || underrun) act <= 1'b0;
      end
    end
  end

  // header bytes leave msb first
  always_ff @(posedge clk) begin
    if (pend)
      sh <= hdr_bytes;
    else if (act)
      sh <= sh << 8;
  end

endmodule

/* hw/ipv4_hdr_builder.sv */
`timescale 1ns/1ps

module ipv4_hdr_builder #(
  parameter int len_w = 16
) (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  ipv4_tx_pkg::dev_t       dev,
  input  logic                    rdy,
  input  ipv4_tx_pkg::ipv4_meta_t meta,
  input  logic                    arp_val,
  input  logic                    arp_err,
  input  ipv4_tx_pkg::mac_addr_t  arp_mac,
  input  logic [15:0]             cks,
  input  logic                    cks_done,
  input  logic                    frame_end,
  input  logic                    underrun,
  output logic                    acc,
  output logic                    tx_err,
  output logic                    arp_req,
  output ipv4_tx_pkg::ip_addr_t   arp_ip,
  output logic                    calc,
  output ipv4_tx_pkg::hdr_bytes_t hdr_bytes,
  output logic                    hdr_rdy,
  output ipv4_tx_pkg::mac_meta_t  mac_meta
);

  ipv4_tx_pkg::tx_state_e state;

  logic        cks_ok;     // checksum already inserted
  logic        cks_now;
  logic        skip_arp;
  logic        take;
  logic [15:0] tot_len;

  assign tot_len  = 16'(meta.pld_len[len_w-1:0]) + 16'(ipv4_tx_pkg::hdr_len);
  assign skip_arp = meta.mac_known || (meta.hdr.dst_ip == '1);  // broadcast needs no lookup
  assign take     = (state == ipv4_tx_pkg::idle) && rdy;
  assign cks_now  = cks_ok || cks_done;

  // ------------------------------------------------------------
  // sequencing
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= ipv4_tx_pkg::idle;
      acc     <= 1'b0;
      calc    <= 1'b0;
      tx_err  <= 1'b0;
      arp_req <= 1'b0;
      hdr_rdy <= 1'b0;
      cks_ok  <= 1'b0;
    end else begin
      acc    <= 1'b0;
      tx_err <= 1'b0;
      calc   <= acc;  // header is settled one cycle after capture
      case (state)
        ipv4_tx_pkg::idle: begin
          cks_ok <= 1'b0;
          if (rdy) begin
            acc     <= 1'b1;
            arp_req <= !skip_arp;
            state   <= skip_arp ? ipv4_tx_pkg::cks_wait : ipv4_tx_pkg::arp_wait;
          end
        end
        ipv4_tx_pkg::arp_wait: begin
          if (cks_done) cks_ok <= 1'b1;  // the sum runs alongside the lookup
          if (arp_err) begin
            arp_req <= 1'b0;
            tx_err  <= 1'b1;
            state   <= ipv4_tx_pkg::idle;
          end else if (arp_val) begin
            arp_req <= 1'b0;
            if (cks_now) begin
              hdr_rdy <= 1'b1;
              state   <= ipv4_tx_pkg::ready;
            end else begin
              state <= ipv4_tx_pkg::cks_wait;
            end
          end
        end
        ipv4_tx_pkg::cks_wait: begin
          if (cks_done) begin
            cks_ok  <= 1'b1;
            hdr_rdy <= 1'b1;
            state   <= ipv4_tx_pkg::ready;
          end
        end
        ipv4_tx_pkg::ready: begin
          state <= ipv4_tx_pkg::sending;  // serializer owns the mac handshake from here
        end
        ipv4_tx_pkg::sending: begin
          if (underrun) begin
            tx_err  <= 1'b1;
            hdr_rdy <= 1'b0;
            state   <= ipv4_tx_pkg::idle;
          end else if (frame_end) begin
            hdr_rdy <= 1'b0;
            state   <= ipv4_tx_pkg::idle;
          end
        end
        default: state <= ipv4_tx_pkg::idle;
      endcase
    end
  end

  // ------------------------------------------------------------
  // header and frame metadata
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (take) begin
      hdr_bytes <= {meta.hdr.ver, meta.hdr.ihl, meta.hdr.qos, tot_len,
                    meta.hdr.id, 1'b0, meta.hdr.df, meta.hdr.mf, meta.hdr.fo,
                    meta.hdr.ttl, meta.hdr.proto, 16'h0000,
                    meta.hdr.src_ip, meta.hdr.dst_ip};
      arp_ip             <= meta.hdr.dst_ip;
      mac_meta.src_mac   <= dev.mac_addr;
      mac_meta.dst_mac   <= meta.dst_mac;
      mac_meta.ethertype <= ipv4_tx_pkg::ethertype_ipv4;
      mac_meta.length    <= tot_len;
    end
    if (cks_done && ((state == ipv4_tx_pkg::arp_wait) || (state == ipv4_tx_pkg::cks_wait)))
      hdr_bytes[9:8] <= cks;  // header bytes 10 and 11
    if ((state == ipv4_tx_pkg::arp_wait) && arp_val)
      mac_meta.dst_mac <= arp_mac;
  end

endmodule

/* hw/ipv4_hdr_checksum.sv */
`timescale 1ns/1ps

module ipv4_hdr_checksum (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  logic                    calc,
  input  ipv4_tx_pkg::hdr_bytes_t hdr_bytes,
  output logic [15:0]             cks,
  output logic                    done
);

  localparam int         words     = ipv4_tx_pkg::hdr_len / 2;
  localparam logic [3:0] last_word = 4'(words);

  ipv4_tx_pkg::hdr_bytes_t sh;

  logic [19:0] sum;         // ten words cannot overflow 20 bits
  logic [3:0]  cnt;
  logic        busy;
  logic [15:0] first_word;
  logic [15:0] next_word;
  logic [16:0] fold_lo;
  logic [15:0] fold_hi;

  assign first_word = {hdr_bytes[ipv4_tx_pkg::hdr_len-1], hdr_bytes[ipv4_tx_pkg::hdr_len-2]};
  assign next_word  = {sh[ipv4_tx_pkg::hdr_len-1], sh[ipv4_tx_pkg::hdr_len-2]};

  // two folds cover the carry out of the first one
  always_comb begin
    fold_lo = {1'b0, sum[15:0]} + 17'(sum[19:16]);
    fold_hi = fold_lo[15:0] + 16'(fold_lo[16]);
  end

  // ------------------------------------------------------------
  // word counter
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt  <= '0;
    end else begin
      done <= 1'b0;
      if (calc) begin
        busy <= 1'b1;  // a new calc restarts a running sum
        cnt  <= 4'd1;
      end else if (busy) begin
        if (cnt == last_word) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          cnt <= cnt + 4'd1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // accumulator
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (calc) begin
      sum <= 20'(first_word);  // first word is added on the latch edge
      sh  <= hdr_bytes << 16;
    end else if (busy && (cnt != last_word)) begin
      sum <= sum + 20'(next_word);
      sh  <= sh << 16;
    end
    if (busy && (cnt == last_word))
      cks <= ~fold_hi;
  end

endmodule

/* hw/ipv4_tx.sv */
`timescale 1ns/1ps

module ipv4_tx #(
  parameter int len_w = 16
) (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  ipv4_tx_pkg::dev_t       dev,
  input  logic                    rdy,
  input  ipv4_tx_pkg::ipv4_meta_t meta,
  input  logic                    arp_val,
  input  logic                    arp_err,
  input  ipv4_tx_pkg::mac_addr_t  arp_mac,
  input  logic                    mac_req,
  input  logic                    pld_val,
  input  logic [7:0]              pld_dat,
  output logic                    acc,
  output logic                    tx_err,
  output logic                    arp_req,
  output ipv4_tx_pkg::ip_addr_t   arp_ip,
  output logic                    mac_rdy,
  output ipv4_tx_pkg::mac_meta_t  mac_meta,
  output ipv4_tx_pkg::byte_strm_t mac_strm,
  output logic                    pld_req
);

  ipv4_tx_pkg::hdr_bytes_t hdr_bytes;

  logic        calc;
  logic [15:0] cks;
  logic        cks_done;
  logic        hdr_rdy;
  logic        frame_end;
  logic        underrun;

  ipv4_hdr_builder #(
    .len_w (len_w)
  ) i_builder (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .dev       (dev),
    .rdy       (rdy),
    .meta      (meta),
    .arp_val   (arp_val),
    .arp_err   (arp_err),
    .arp_mac   (arp_mac),
    .cks       (cks),
    .cks_done  (cks_done),
    .frame_end (frame_end),
    .underrun  (underrun),
    .acc       (acc),
    .tx_err    (tx_err),
    .arp_req   (arp_req),
    .arp_ip    (arp_ip),
    .calc      (calc),
    .hdr_bytes (hdr_bytes),
    .hdr_rdy   (hdr_rdy),
    .mac_meta  (mac_meta)
  );

  ipv4_hdr_checksum i_checksum (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .calc      (calc),
    .hdr_bytes (hdr_bytes),
    .cks       (cks),
    .done      (cks_done)
  );

  ipv4_frame_serializer #(
    .len_w (len_w)
  ) i_serializer (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .hdr_rdy   (hdr_rdy),
    .hdr_bytes (hdr_bytes),
    .frame_len (mac_meta.length[len_w-1:0]),  // len_w is at most 16
    .mac_req   (mac_req),
    .pld_val   (pld_val),
    .pld_dat   (pld_dat),
    .mac_rdy   (mac_rdy),
    .mac_strm  (mac_strm),
    .pld_req   (pld_req),
    .frame_end (frame_end),
    .underrun  (underrun)
  );

endmodule

/* hw/ipv4_tx_pkg.sv */
package ipv4_tx_pkg;

  // ------------------------------------------------------------
  // header constants
  // ------------------------------------------------------------

  localparam int          hdr_len        = 20;      // no options, ihl is always 5
  localparam logic [15:0] ethertype_ipv4 = 16'h0800;

  typedef logic [5:0][7:0]         mac_addr_t;
  typedef logic [3:0][7:0]         ip_addr_t;
  typedef logic [hdr_len-1:0][7:0] hdr_bytes_t;    // byte hdr_len-1 goes out first

  // ------------------------------------------------------------
  // enums
  // ------------------------------------------------------------

  typedef enum logic [7:0] {
    icmp = 8'd1,
    tcp  = 8'd6,
    udp  = 8'd17
  } ip_proto_e;

  typedef enum logic [2:0] {
    idle,
    arp_wait,
    cks_wait,
    ready,
    sending
  } tx_state_e;

  // ------------------------------------------------------------
  // structs
  // ------------------------------------------------------------

  typedef struct packed {
    logic [3:0]  ver;
    logic [3:0]  ihl;
    logic [7:0]  qos;
    logic [15:0] id;
    logic        df;
    logic        mf;
    logic [12:0] fo;    // copied into the header, never acted on
    logic [7:0]  ttl;
    ip_proto_e   proto;
    ip_addr_t    src_ip;
    ip_addr_t    dst_ip;
  } ipv4_hdr_t;

  typedef struct packed {
    ipv4_hdr_t   hdr;
    logic [15:0] pld_len;
    logic        mac_known;  // dst_mac is valid, skip the lookup
    mac_addr_t   dst_mac;
  } ipv4_meta_t;

  typedef struct packed {
    mac_addr_t   src_mac;
    mac_addr_t   dst_mac;
    logic [15:0] ethertype;
    logic [15:0] length;     // ip header plus payload
  } mac_meta_t;

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
  } byte_strm_t;

  typedef struct packed {
    mac_addr_t mac_addr;
    ip_addr_t  ipv4_addr;
  } dev_t;

endpackage

/* run_sim.sh */
#!/bin/sh
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module ipv4_tx_tb -o ipv4_tx_sim > build.log 2>&1; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/ipv4_tx_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

/* sim.f */
hw/ipv4_tx_pkg.sv
hw/ipv4_hdr_builder.sv
hw/ipv4_hdr_checksum.sv
hw/ipv4_frame_serializer.sv
hw/ipv4_tx.sv
tests/ipv4_tx_properties.sv
tests/ipv4_tx_tb.sv

/* tests/ipv4_tx_properties.sv */
`timescale 1ns/1ps

module ipv4_tx_properties (
  input logic                    clk,
  input logic                    fsm_rst,
  input logic                    acc,
  input logic                    tx_err,
  input logic                    arp_req,
  input logic                    arp_val,
  input logic                    arp_err,
  input ipv4_tx_pkg::ip_addr_t   arp_ip,
  input logic                    mac_rdy,
  input logic                    mac_req,
  input ipv4_tx_pkg::byte_strm_t mac_strm,
  input logic                    pld_req,
  input logic                    underrun,
  input ipv4_tx_pkg::tx_state_e  state
);

  // ------------------------------------------------------------
  // reset and client side
  // ------------------------------------------------------------

  a_reset_quiet: assert property (@(posedge clk) fsm_rst |=>
    !(acc || tx_err || arp_req || mac_rdy || mac_strm.val || mac_strm.sof ||
      mac_strm.eof || pld_req))
    else $error("outputs not cleared by reset");

  a_acc_pulse: assert property (@(posedge clk) disable iff (fsm_rst) acc |=> !acc)
    else $error("acc longer than one cycle");

  // lookup request is a level held until the table answers
  a_arp_hold: assert property (@(posedge clk) disable iff (fsm_rst)
    arp_req && !arp_val && !arp_err |=> arp_req && $stable(arp_ip))
    else $error("arp_req or arp_ip changed before the answer");

  // ------------------------------------------------------------
  // mac side
  // ------------------------------------------------------------

  a_sof_delay: assert property (@(posedge clk) disable iff (fsm_rst)
    mac_req && mac_rdy |-> ##2 mac_strm.sof)
    else $error("sof not two cycles after mac_req");

  a_val_run: assert property (@(posedge clk) disable iff (fsm_rst)
    mac_strm.val && !mac_strm.eof |=> mac_strm.val || underrun)
    else $error("gap in the byte stream");

  a_underrun_err: assert property (@(posedge clk) disable iff (fsm_rst) underrun |=> tx_err)
    else $error("underrun without tx_err");

  a_back_idle: assert property (@(posedge clk) disable iff (fsm_rst)
    mac_strm.eof |=> state == ipv4_tx_pkg::idle)
    else $error("builder not idle after the last byte");

endmodule

/* tests/ipv4_tx_tb.sv */
`timescale 1ns/1ps

module ipv4_tx_tb;

  localparam int limit = 200;  // cycles per wait
  localparam int ev_acc = 0;
  localparam int ev_arp = 1;
  localparam int ev_mac = 2;
  localparam int ev_pld = 3;
  localparam int ev_eof = 4;
  localparam int ev_err = 5;

  logic                    clk;
  logic                    fsm_rst;
  ipv4_tx_pkg::dev_t       dev;
  logic                    rdy;
  ipv4_tx_pkg::ipv4_meta_t meta;
  logic                    arp_val;
  logic                    arp_err;
  ipv4_tx_pkg::mac_addr_t  arp_mac;
  logic                    mac_req;
  logic                    pld_val;
  logic [7:0]              pld_dat;
  logic                    acc;
  logic                    tx_err;
  logic                    arp_req;
  ipv4_tx_pkg::ip_addr_t   arp_ip;
  logic                    mac_rdy;
  ipv4_tx_pkg::mac_meta_t  mac_meta;
  ipv4_tx_pkg::byte_strm_t mac_strm;
  logic                    pld_req;

  // expected values of the packet in flight
  logic [7:0]             exp_hdr [20];
  int                     exp_len;
  ipv4_tx_pkg::mac_addr_t exp_dst_mac;
  ipv4_tx_pkg::ip_addr_t  exp_dst_ip;
  bit                     exp_arp;
  bit                     exp_arp_err;
  logic [7:0]             pld_base;
  int                     idx;
  logic [31:0]            hsum;
  bit                     frame_done;
  int                     err_cnt;
  int                     err_ref;

  ipv4_tx #(
    .len_w (16)
  ) i_ipv4_tx (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .dev      (dev),
    .rdy      (rdy),
    .meta     (meta),
    .arp_val  (arp_val),
    .arp_err  (arp_err),
    .arp_mac  (arp_mac),
    .mac_req  (mac_req),
    .pld_val  (pld_val),
    .pld_dat  (pld_dat),
    .acc      (acc),
    .tx_err   (tx_err),
    .arp_req  (arp_req),
    .arp_ip   (arp_ip),
    .mac_rdy  (mac_rdy),
    .mac_meta (mac_meta),
    .mac_strm (mac_strm),
    .pld_req  (pld_req)
  );

  bind ipv4_tx ipv4_tx_properties i_props (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .acc      (acc),
    .tx_err   (tx_err),
    .arp_req  (arp_req),
    .arp_val  (arp_val),
    .arp_err  (arp_err),
    .arp_ip   (arp_ip),
    .mac_rdy  (mac_rdy),
    .mac_req  (mac_req),
    .mac_strm (mac_strm),
    .pld_req  (pld_req),
    .underrun (underrun),
    .state    (i_builder.state)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("TEST FAILED");
    $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("TEST FAILED");
    $display("timed out while waiting for %s", what);
    $fatal(1);
  endtask

  function automatic logic [15:0] fold_sum(input logic [31:0] s);
    logic [31:0] t;
    t = {16'h0, s[15:0]} + {16'h0, s[31:16]};
    t = {16'h0, t[15:0]} + {16'h0, t[31:16]};
    return t[15:0];
  endfunction

  task automatic wait_for_event(input int kind, input string what);
    int  n;
    bit  hit;
    n   = 0;
    hit = 1'b0;
    while (!hit) begin
      @(posedge clk);
      case (kind)
        ev_acc:  hit = acc;
        ev_arp:  hit = arp_req;
        ev_mac:  hit = mac_rdy;
        ev_pld:  hit = pld_req;
        ev_eof:  hit = frame_done;
        default: hit = (err_cnt != err_ref);
      endcase
      n++;
      if (!hit && n > limit) report_timeout(what);
    end
  endtask

  // ------------------------------------------------------------
  // payload source and packet sequencing
  // ------------------------------------------------------------

  task automatic feed_payload(input int len, input int gap);
    int i;
    wait_for_event(ev_pld, "pld_req");
    repeat (3) @(posedge clk);  // first payload slot follows header byte 19
    for (i = 0; i < len; i++) begin
      if (i == gap) break;
      pld_val <= 1'b1;
      pld_dat <= 8'(pld_base + i);
      @(posedge clk);
    end
    pld_val <= 1'b0;
  endtask

  task automatic send_packet(input int len, input bit known, input bit bcast,
                             input bit arp_fail, input int gap);
    ipv4_tx_pkg::ipv4_meta_t m;
    ipv4_tx_pkg::mac_addr_t  ans;
    logic [15:0]             tot;
    int                      d;
    int                      k;
    m             = '0;
    m.hdr.ver     = 4'd4;
    m.hdr.ihl     = 4'd5;
    m.hdr.qos     = 8'($urandom);
    m.hdr.id      = 16'($urandom);
    m.hdr.df      = 1'($urandom);
    m.hdr.mf      = 1'($urandom);
    m.hdr.fo      = 13'($urandom);
    m.hdr.ttl     = 8'(64 + $urandom % 64);
    case ($urandom % 3)
      0:       m.hdr.proto = ipv4_tx_pkg::icmp;
      1:       m.hdr.proto = ipv4_tx_pkg::tcp;
      default: m.hdr.proto = ipv4_tx_pkg::udp;
    endcase
    m.hdr.src_ip  = dev.ipv4_addr;
    m.hdr.dst_ip  = bcast ? '1 : {8'd10, 8'($urandom), 8'($urandom), 8'(1 + $urandom % 200)};
    m.pld_len     = 16'(len);
    m.mac_known   = known;
    m.dst_mac     = bcast ? '1 : 48'({$urandom, $urandom});
    ans           = 48'({$urandom, $urandom});
    tot           = 16'(len + 20);
    exp_hdr[0]    = {m.hdr.ver, m.hdr.ihl};
    exp_hdr[1]    = m.hdr.qos;
    exp_hdr[2]    = tot[15:8];
    exp_hdr[3]    = tot[7:0];
    exp_hdr[4]    = m.hdr.id[15:8];
    exp_hdr[5]    = m.hdr.id[7:0];
    exp_hdr[6]    = {1'b0, m.hdr.df, m.hdr.mf, m.hdr.fo[12:8]};
    exp_hdr[7]    = m.hdr.fo[7:0];
    exp_hdr[8]    = m.hdr.ttl;
    exp_hdr[9]    = m.hdr.proto;
    exp_hdr[10]   = 8'h00;
    exp_hdr[11]   = 8'h00;
    for (k = 0; k < 4; k++) begin
      exp_hdr[12 + k] = m.hdr.src_ip[3 - k];
      exp_hdr[16 + k] = m.hdr.dst_ip[3 - k];
    end
    exp_len     = len;
    exp_dst_ip  = m.hdr.dst_ip;
    exp_arp     = !known && !bcast;
    exp_arp_err = arp_fail;
    exp_dst_mac = exp_arp ? ans : m.dst_mac;
    pld_base    = 8'($urandom);
    err_ref     = err_cnt;

    @(posedge clk);
    rdy  <= 1'b1;
    meta <= m;
    wait_for_event(ev_acc, "acc");
    rdy <= 1'b0;

    if (exp_arp) begin  // table answers after a random delay
      wait_for_event(ev_arp, "arp_req");
      d = 1 + $urandom % 6;
      repeat (d) @(posedge clk);
      if (arp_fail) begin
        arp_err <= 1'b1;
      end else begin
        arp_val <= 1'b1;
        arp_mac <= ans;
      end
      @(posedge clk);
      arp_val <= 1'b0;
      arp_err <= 1'b0;
    end

    if (arp_fail) begin
      wait_for_event(ev_err, "tx_err after the ARP error");
      mac_req <= 1'b1;  // a MAC that would take any frame offered now
      repeat (16) @(posedge clk);
      mac_req <= 1'b0;
      assert (err_cnt == err_ref + 1) else report_mismatch("tx_err count", err_cnt, err_ref + 1);
      assert (idx == 0) else report_mismatch("mac_strm.val count", idx, 0);
      return;
    end

    wait_for_event(ev_mac, "mac_rdy");
    d = $urandom % 5;
    repeat (d) @(posedge clk);
    mac_req <= 1'b1;
    @(posedge clk);
    mac_req <= 1'b0;
    feed_payload(len, gap);

    if (gap >= 0) begin
      wait_for_event(ev_err, "tx_err after the underrun");
      repeat (2) @(posedge clk);
      assert (!frame_done) else report_mismatch("mac_strm.eof", 1, 0);
      assert (idx == gap + 20) else report_mismatch("byte count", idx, gap + 20);
    end else begin
      wait_for_event(ev_eof, "eof");
      repeat (2) @(posedge clk);
      assert (err_cnt == err_ref) else report_mismatch("tx_err count", err_cnt, err_ref);
      assert (idx == len + 20) else report_mismatch("byte count", idx, len + 20);
    end
  endtask

  // ------------------------------------------------------------
  // checks on the DUT outputs
  // ------------------------------------------------------------

  assert property (@(posedge clk) disable iff (fsm_rst) arp_req |-> arp_ip == exp_dst_ip)
    else report_mismatch("arp_ip", arp_ip, exp_dst_ip);

  assert property (@(posedge clk) disable iff (fsm_rst) tx_err |=> !tx_err)
    else report_mismatch("tx_err", 1, 0);

  always @(posedge clk) begin
    if (!fsm_rst) begin
      if (acc) begin
        idx        = 0;
        hsum       = '0;
        frame_done = 1'b0;
      end
      if (tx_err) err_cnt++;
      if (arp_req) assert (exp_arp) else report_mismatch("arp_req", 1, 0);
      if (mac_rdy) begin
        assert (!exp_arp_err) else report_mismatch("mac_rdy", 1, 0);
        assert (mac_meta.src_mac == dev.mac_addr)
          else report_mismatch("mac_meta.src_mac", mac_meta.src_mac, dev.mac_addr);
        assert (mac_meta.dst_mac == exp_dst_mac)
          else report_mismatch("mac_meta.dst_mac", mac_meta.dst_mac, exp_dst_mac);
        assert (mac_meta.ethertype == 16'h0800)
          else report_mismatch("mac_meta.ethertype", mac_meta.ethertype, 16'h0800);
        assert (mac_meta.length == 16'(exp_len + 20))
          else report_mismatch("mac_meta.length", mac_meta.length, exp_len + 20);
      end
      if (mac_strm.val) begin
        assert (mac_strm.sof == (idx == 0))
          else report_mismatch("mac_strm.sof", mac_strm.sof, idx == 0);
        assert (mac_strm.eof == (idx == exp_len + 19))
          else report_mismatch("mac_strm.eof", mac_strm.eof, idx == exp_len + 19);
        if (idx < 20) begin
          if (idx != 10 && idx != 11)
            assert (mac_strm.dat == exp_hdr[idx])
              else report_mismatch("mac_strm.dat", mac_strm.dat, exp_hdr[idx]);
          if (idx % 2 == 0) hsum = hsum + {16'h0, mac_strm.dat, 8'h00};
          else hsum = hsum + {24'h0, mac_strm.dat};
          if (idx == 19)
            assert (fold_sum(hsum) == 16'hffff)
              else report_mismatch("header checksum", fold_sum(hsum), 16'hffff);
        end else begin
          assert (mac_strm.dat == 8'(pld_base + idx - 20))
            else report_mismatch("mac_strm.dat", mac_strm.dat, 8'(pld_base + idx - 20));
        end
        if (mac_strm.eof) frame_done = 1'b1;
        idx++;
      end
    end
  end

  initial begin
    void'($urandom(82283));
    fsm_rst     = 1'b1;
    dev         = {48'h02_00_5e_10_20_30, 32'hc0_a8_0a_02};
    rdy         = 1'b0;
    meta        = '0;
    arp_val     = 1'b0;
    arp_err     = 1'b0;
    arp_mac     = '0;
    mac_req     = 1'b0;
    pld_val     = 1'b0;
    pld_dat     = 8'h00;
    idx         = 0;
    hsum        = '0;
    frame_done  = 1'b0;
    err_cnt     = 0;
    err_ref     = 0;
    exp_arp     = 1'b0;
    exp_arp_err = 1'b0;
    exp_len     = 0;
    repeat (3) @(posedge clk);
    fsm_rst <= 1'b0;
    repeat (2) @(posedge clk);

    send_packet(8, 1'b1, 1'b0, 1'b0, -1);   // known mac
    send_packet(30, 1'b0, 1'b0, 1'b0, -1);  // lookup
    send_packet(5, 1'b0, 1'b1, 1'b0, -1);   // broadcast
    send_packet(12, 1'b0, 1'b0, 1'b1, -1);  // lookup fails
    send_packet(12, 1'b0, 1'b0, 1'b0, -1);
    send_packet(10, 1'b1, 1'b0, 1'b0, 3);   // payload underrun
    send_packet(6, 1'b0, 1'b0, 1'b0, -1);

    $display("TEST PASSED");
    $finish;
  end

endmodule
